//--- hdl/command_decoder.sv
// Command word FSM with control registers, move field writes and reply words
`default_nettype none
`include "motion_defines.svh"

module command_decoder (
  input  logic                   CLK,
  input  logic                   resetn,
  input  motion_pkg::word_t      word_data_received,
  input  logic                   word_received,
  output motion_pkg::word_t      word_send_data,
  output motion_pkg::axis_mask_t enable,
  output motion_pkg::axis_mask_t brake,
  output motion_pkg::divisor_t   divisor,
  input  motion_pkg::position_t  positions [`NUM_MOTORS],
  move_write_if.decoder          wr
);

  localparam int CNT_BITS = $clog2(2 * `NUM_MOTORS + 1);
  localparam logic [CNT_BITS-1:0] LAST_WORD = CNT_BITS'(2 * `NUM_MOTORS);

  motion_pkg::decoder_state_e state;
  motion_pkg::opcode_e        header;
  motion_pkg::axis_index_t    word_axis;
  motion_pkg::position_t      pos_snap [`NUM_MOTORS];
  logic [CNT_BITS-1:0]        word_cnt;   // Words seen after a move header
  logic                       strobe_q;
  logic                       strobe_rise;

  // Sign extend a step position into a reply word
  function automatic motion_pkg::word_t pos_word(motion_pkg::position_t p);
    return {{(`WORD_BITS - 32){p[31]}}, p};
  endfunction

  assign header    = motion_pkg::opcode_e'(word_data_received[`WORD_BITS-1 -: 8]);
  assign word_axis = motion_pkg::axis_index_t'((word_cnt - 1'b1) >> 1);

  // Field values follow every word, the strobes say which one is meant
  always_ff @(posedge CLK) begin
    if (strobe_rise) begin
      wr.dir      <= word_data_received[`NUM_MOTORS-1:0];
      wr.duration <= word_data_received[`DURATION_BITS-1:0];
      wr.axis     <= word_axis;
      wr.rate     <= word_data_received[`DDA_BITS-1:0];
      wr.accel    <= word_data_received[`DDA_BITS-1:0];
      if (state == motion_pkg::DEC_IDLE && header == motion_pkg::COORDINATED_STEP) begin
        pos_snap <= positions;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      state          <= motion_pkg::DEC_IDLE;
      word_cnt       <= '0;
      strobe_q       <= 1'b0;
      strobe_rise    <= 1'b0;
      word_send_data <= '0;
      enable         <= '0;
      brake          <= '0;
      divisor        <= motion_pkg::divisor_t'(`DEFAULT_DIVISOR);
      wr.wr_dir      <= 1'b0;
      wr.wr_duration <= 1'b0;
      wr.wr_rate     <= 1'b0;
      wr.wr_accel    <= 1'b0;
      wr.commit      <= 1'b0;
    end else begin
      strobe_q       <= word_received;
      strobe_rise    <= word_received & ~strobe_q; // Word consumed next cycle
      wr.wr_dir      <= 1'b0;
      wr.wr_duration <= 1'b0;
      wr.wr_rate     <= 1'b0;
      wr.wr_accel    <= 1'b0;
      wr.commit      <= 1'b0;
      if (strobe_rise) begin
        word_send_data <= '0;
        case (state)
          motion_pkg::DEC_IDLE: begin
            case (header)
              motion_pkg::COORDINATED_STEP: begin
                wr.wr_dir <= 1'b1;
                word_cnt  <= '0;
                state     <= motion_pkg::DEC_MOVE_WORDS;
              end
              motion_pkg::MOTOR_ENABLE: enable  <= word_data_received[`NUM_MOTORS-1:0];
              motion_pkg::MOTOR_BRAKE:  brake   <= word_data_received[`NUM_MOTORS-1:0];
              motion_pkg::CLK_DIVISOR:  divisor <= word_data_received[7:0];
              motion_pkg::API_VERSION: begin
                word_send_data <= {{(`WORD_BITS - 32){1'b0}}, `VERSION_DEVEL,
                                   `VERSION_MAJOR, `VERSION_MINOR, `VERSION_PATCH};
                state          <= motion_pkg::DEC_TAIL_WORD;
              end
              default: word_send_data <= '0; // Unknown header
            endcase
          end
          motion_pkg::DEC_MOVE_WORDS: begin
            word_cnt <= word_cnt + 1'b1;
            if (word_cnt == '0) begin
              wr.wr_duration <= 1'b1;
              word_send_data <= pos_word(pos_snap[0]);
            end else if (word_cnt[0]) begin
              wr.wr_rate <= 1'b1; // Odd words carry a rate
            end else if (word_cnt == LAST_WORD) begin
              wr.wr_accel <= 1'b1;
              wr.commit   <= 1'b1;
              state       <= motion_pkg::DEC_IDLE;
            end else begin
              wr.wr_accel    <= 1'b1;
              word_send_data <= pos_word(pos_snap[word_axis + 1'b1]);
            end
          end
          default: state <= motion_pkg::DEC_IDLE; // Word after the version query
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/dda_axis.sv
// Per-axis DDA accumulator with rate ramp, step pulse and step position
`default_nettype none
`include "motion_defines.svh"

module dda_axis #(
  parameter int axis_index = 0
) (
  input  logic                  CLK,
  input  logic                  resetn,
  input  logic                  tick,
  move_read_if.axis             rd,
  output logic                  step,
  output motion_pkg::position_t position
);

  motion_pkg::dda_t    acc;
  motion_pkg::dda_t    rate;   // Live rate, ramps by accel each tick
  motion_pkg::dda_t    accel;
  logic [`DDA_BITS:0]  sum;

  assign sum = {1'b0, acc} + {1'b0, rate}; // Top bit is the carry

  always_ff @(posedge CLK) begin
    if (rd.load) begin
      acc   <= '0;
      rate  <= rd.rate[axis_index];
      accel <= rd.accel[axis_index];
    end else if (rd.run && tick) begin
      acc  <= sum[`DDA_BITS-1:0];
      rate <= rate + accel;
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      step     <= 1'b0;
      position <= '0;
    end else begin
      step <= rd.run & tick & sum[`DDA_BITS];
      if (rd.run && tick && sum[`DDA_BITS]) begin
        position <= rd.dir[axis_index] ? position + 32'sd1 : position - 32'sd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/dda_sequencer.sv
// FSM that loads, times and retires buffered moves in slot order
`default_nettype none
`include "motion_defines.svh"

module dda_sequencer (
  input  logic            CLK,
  input  logic            resetn,
  input  logic            tick,
  move_read_if.sequencer  rd,
  output logic            move_done
);

  motion_pkg::seq_state_e state;
  motion_pkg::duration_t  remaining;  // Ticks left in the running move
  motion_pkg::slot_t      rd_idx;

  assign rd.rd_slot = rd_idx;
  assign rd.load    = (state == motion_pkg::SEQ_LOAD);
  assign rd.run     = (state == motion_pkg::SEQ_RUN);
  assign rd.retire  = (state == motion_pkg::SEQ_RETIRE);
  assign move_done  = rd.retire;

  always_ff @(posedge CLK) begin
    if (resetn) begin
      state     <= motion_pkg::SEQ_IDLE;
      remaining <= '0;
      rd_idx    <= '0;
    end else begin
      case (state)
        motion_pkg::SEQ_IDLE: begin
          if (rd.slot_ready) state <= motion_pkg::SEQ_LOAD;
        end
        motion_pkg::SEQ_LOAD: begin
          remaining <= rd.duration;
          state <= (rd.duration == '0) ? motion_pkg::SEQ_RETIRE : motion_pkg::SEQ_RUN;
        end
        motion_pkg::SEQ_RUN: begin
          if (tick) begin
            remaining <= remaining - 1'b1;
            if (remaining == motion_pkg::duration_t'(1)) state <= motion_pkg::SEQ_RETIRE;
          end
        end
        default: begin
          // Hand the slot back and move on
          rd_idx <= (rd_idx == motion_pkg::slot_t'(`BUFFER_SLOTS - 1)) ? '0 : rd_idx + 1'b1;
          state  <= motion_pkg::SEQ_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/motion_defines.svh
// Word, axis, buffer and DDA widths, default tick divisor and API version bytes
`ifndef MOTION_DEFINES_SVH
`define MOTION_DEFINES_SVH

// Host word and axis count
`define WORD_BITS 64
`define NUM_MOTORS 2

// Move buffer depth
`define BUFFER_SLOTS 2

// DDA accumulator and move length
`define DDA_BITS 32
`define DURATION_BITS 32

`define DEFAULT_DIVISOR 4 // CLK cycles per DDA tick

// API version reply bytes
`define VERSION_MAJOR 8'h01
`define VERSION_MINOR 8'h02
`define VERSION_PATCH 8'h03
`define VERSION_DEVEL 8'h00

`endif

//--- hdl/motion_pkg.sv
// Motion core typedefs, command opcodes and decoder and sequencer state encodings
`default_nettype none
`include "motion_defines.svh"

package motion_pkg;

  localparam int SLOT_BITS = (`BUFFER_SLOTS > 1) ? $clog2(`BUFFER_SLOTS) : 1;
  localparam int AXIS_BITS = (`NUM_MOTORS > 1) ? $clog2(`NUM_MOTORS) : 1;

  typedef logic [`WORD_BITS-1:0]     word_t;
  typedef logic [`NUM_MOTORS-1:0]    axis_mask_t;  // Dir, enable, brake, step
  typedef logic [`DDA_BITS-1:0]      dda_t;        // Rate, accel, accumulator
  typedef logic [`DURATION_BITS-1:0] duration_t;   // In DDA ticks
  typedef logic signed [31:0]        position_t;
  typedef logic [7:0]                divisor_t;
  typedef logic [SLOT_BITS-1:0]      slot_t;
  typedef logic [AXIS_BITS-1:0]      axis_index_t;

  // Header byte, word bits 63:56
  typedef enum logic [7:0] {
    COORDINATED_STEP = 8'h01,
    MOTOR_ENABLE     = 8'h0a,
    MOTOR_BRAKE      = 8'h0b,
    CLK_DIVISOR      = 8'h20,
    API_VERSION      = 8'hfe
  } opcode_e;

  typedef enum logic [1:0] {DEC_IDLE, DEC_MOVE_WORDS, DEC_TAIL_WORD} decoder_state_e;

  typedef enum logic [1:0] {SEQ_IDLE, SEQ_LOAD, SEQ_RUN, SEQ_RETIRE} seq_state_e;

endpackage

`default_nettype wire

//--- hdl/motion_top.sv
// Stepper motion core top level with command decoder, move buffer, tick, sequencer and axes
`default_nettype none
`include "motion_defines.svh"

module motion_top (
  input  logic                   CLK,
  input  logic                   resetn,
  input  motion_pkg::word_t      word_data_received,
  input  logic                   word_received,
  output motion_pkg::word_t      word_send_data,
  output logic                   buffer_dtr,
  output logic                   move_done,
  output motion_pkg::axis_mask_t step,
  output motion_pkg::axis_mask_t dir,
  output motion_pkg::axis_mask_t enable,
  output motion_pkg::axis_mask_t brake
);

  move_write_if wr_bus ();
  move_read_if  rd_bus ();

  motion_pkg::divisor_t  divisor;
  motion_pkg::position_t positions [`NUM_MOTORS];
  logic                  tick;

  command_decoder u_decoder (
    .CLK                (CLK),
    .resetn             (resetn),
    .word_data_received (word_data_received),
    .word_received      (word_received),
    .word_send_data     (word_send_data),
    .enable             (enable),
    .brake              (brake),
    .divisor            (divisor),
    .positions          (positions),
    .wr                 (wr_bus)
  );

  move_buffer u_buffer (.CLK(CLK), .resetn(resetn), .wr(wr_bus), .rd(rd_bus));

  tick_divider u_tick (.CLK(CLK), .resetn(resetn), .divisor(divisor), .tick(tick));

  dda_sequencer u_seq (
    .CLK(CLK), .resetn(resetn), .tick(tick), .rd(rd_bus), .move_done(move_done)
  );

  for (genvar a = 0; a < `NUM_MOTORS; a++) begin : g_axis
    dda_axis #(.axis_index(a)) u_axis (
      .CLK      (CLK),
      .resetn   (resetn),
      .tick     (tick),
      .rd       (rd_bus),
      .step     (step[a]),
      .position (positions[a])
    );
  end

  assign dir        = rd_bus.dir;     // Direction of the slot being run
  assign buffer_dtr = ~wr_bus.full;

endmodule

`default_nettype wire

//--- hdl/move_buffer.sv
// Two-slot move storage with ready and consumed toggle flags
`default_nettype none
`include "motion_defines.svh"

module move_buffer (
  input  logic          CLK,
  input  logic          resetn,
  move_write_if.buffer  wr,
  move_read_if.buffer   rd
);

  localparam int SLOTS = `BUFFER_SLOTS;

  motion_pkg::axis_mask_t dir_mem      [SLOTS];
  motion_pkg::duration_t  duration_mem [SLOTS];
  motion_pkg::dda_t       rate_mem     [SLOTS][`NUM_MOTORS];
  motion_pkg::dda_t       accel_mem    [SLOTS][`NUM_MOTORS];
  logic [SLOTS-1:0]       ready_tgl;
  logic [SLOTS-1:0]       consumed_tgl;
  logic [SLOTS-1:0]       pending;
  motion_pkg::slot_t      wr_idx;

  assign pending       = ready_tgl ^ consumed_tgl; // Flags differ while a move waits
  assign wr.slot       = wr_idx;
  assign wr.full       = &pending;
  assign rd.slot_ready = pending[rd.rd_slot];
  assign rd.duration   = duration_mem[rd.rd_slot];
  assign rd.dir        = dir_mem[rd.rd_slot];

  for (genvar a = 0; a < `NUM_MOTORS; a++) begin : g_axis_fields
    assign rd.rate[a]  = rate_mem[rd.rd_slot][a];
    assign rd.accel[a] = accel_mem[rd.rd_slot][a];
  end

  always_ff @(posedge CLK) begin
    if (wr.wr_dir)      dir_mem[wr_idx]               <= wr.dir;
    if (wr.wr_duration) duration_mem[wr_idx]          <= wr.duration;
    if (wr.wr_rate)     rate_mem[wr_idx][wr.axis]     <= wr.rate;
    if (wr.wr_accel)    accel_mem[wr_idx][wr.axis]    <= wr.accel;
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      ready_tgl    <= '0;
      consumed_tgl <= '0;
      wr_idx       <= '0;
    end else begin
      if (wr.commit) begin
        ready_tgl[wr_idx] <= ~ready_tgl[wr_idx];
        wr_idx <= (wr_idx == motion_pkg::slot_t'(SLOTS - 1)) ? '0 : wr_idx + 1'b1;
      end
      if (rd.retire) consumed_tgl[rd.rd_slot] <= ~consumed_tgl[rd.rd_slot];
    end
  end

endmodule

`default_nettype wire

//--- hdl/move_read_if.sv
// Move read bus from the move buffer to the DDA sequencer and the axes
`default_nettype none
`include "motion_defines.svh"

interface move_read_if;

  motion_pkg::slot_t      rd_slot;
  motion_pkg::duration_t  duration;
  motion_pkg::axis_mask_t dir;
  motion_pkg::dda_t       rate [`NUM_MOTORS];
  motion_pkg::dda_t       accel [`NUM_MOTORS];
  logic                   slot_ready;  // Read slot holds a pending move
  logic                   retire;
  logic                   load;
  logic                   run;

  modport buffer (input rd_slot, retire,
                  output duration, dir, rate, accel, slot_ready);
  modport sequencer (input duration, slot_ready,
                     output rd_slot, retire, load, run);
  modport axis (input dir, rate, accel, load, run);

endinterface

`default_nettype wire

//--- hdl/move_write_if.sv
// Move write bus from the command decoder into the move buffer
`default_nettype none

interface move_write_if;

  motion_pkg::slot_t       slot;     // Current write slot, owned by the buffer
  motion_pkg::axis_mask_t  dir;
  motion_pkg::duration_t   duration;
  motion_pkg::axis_index_t axis;
  motion_pkg::dda_t        rate;
  motion_pkg::dda_t        accel;
  logic                    wr_dir;
  logic                    wr_duration;
  logic                    wr_rate;
  logic                    wr_accel;
  logic                    commit;   // Last field of a move written
  logic                    full;

  modport decoder (input slot, full, output dir, duration, axis, rate, accel,
                   wr_dir, wr_duration, wr_rate, wr_accel, commit);
  modport buffer (output slot, full, input dir, duration, axis, rate, accel,
                  wr_dir, wr_duration, wr_rate, wr_accel, commit);

endinterface

`default_nettype wire

//--- hdl/tick_divider.sv
// Programmable down counter that makes the DDA tick
`default_nettype none

module tick_divider (
  input  logic                 CLK,
  input  logic                 resetn,
  input  motion_pkg::divisor_t divisor,
  output logic                 tick
);

  motion_pkg::divisor_t count;
  motion_pkg::divisor_t divisor_q; // Last divisor seen

  always_ff @(posedge CLK) begin
    if (resetn) begin
      count     <= '0;
      divisor_q <= '0;
      tick      <= 1'b0;
    end else if (divisor != divisor_q) begin
      divisor_q <= divisor;  // Restart on a new divisor
      count     <= divisor - 1'b1;
      tick      <= 1'b0;
    end else if (count == '0) begin
      count <= divisor - 1'b1;
      tick  <= 1'b1;
    end else begin
      count <= count - 1'b1;
      tick  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+hdl
hdl/motion_pkg.sv
hdl/move_write_if.sv
hdl/move_read_if.sv
hdl/command_decoder.sv
hdl/move_buffer.sv
hdl/tick_divider.sv
hdl/dda_sequencer.sv
hdl/dda_axis.sv
hdl/motion_top.sv
test/tb_motion.sv

//--- test/tb_motion.sv
// Table-driven testbench for the motion core with host word driver, step counting and watchdog
`default_nettype none
`include "motion_defines.svh"

module tb_motion;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NROWS = 8;
  localparam int NAX = `NUM_MOTORS;

  logic CLK, resetn, word_received, buffer_dtr, move_done;
  motion_pkg::word_t word_data_received, word_send_data;
  motion_pkg::axis_mask_t step, dir, enable, brake;

  // Test table, one entry per host command
  logic [7:0]  row_op [NROWS];
  logic [55:0] row_arg [NROWS];
  logic [31:0] row_dur [NROWS];
  logic [63:0] row_reply [NROWS];
  logic [1:0]  row_en [NROWS], row_br [NROWS], row_dir2 [NROWS];
  logic        row_pair [NROWS];
  logic [31:0] row_dur2 [NROWS];

  integer nrows = 0, errors = 0, n_checks = 0, seed = 32'h94e5;
  integer step_cnt [NAX], exp_steps [NAX], done_cnt, watchdog_cycles, i;
  logic signed [31:0] pos_model [NAX];
  logic [1:0] dir_hist [16];   // Direction seen at each move_done
  logic table_ready = 1'b0;

  motion_top u_dut (.*);

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // Step and move_done counters
  always @(posedge CLK) begin
    if (resetn) begin
      done_cnt = 0;
      for (int a = 0; a < NAX; a++) step_cnt[a] = 0;
    end else begin
      for (int a = 0; a < NAX; a++) if (step[a]) step_cnt[a] = step_cnt[a] + 1;
      if (move_done) begin
        dir_hist[done_cnt] = dir;
        done_cnt = done_cnt + 1;
      end
    end
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    n_checks = n_checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("** Error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic add_row(input logic [7:0] op, input logic [55:0] arg, input logic [31:0] dur,
                         input logic [63:0] reply, input logic [1:0] en, input logic [1:0] br,
                         input logic pair, input logic [1:0] dir2, input logic [31:0] dur2);
    row_op[nrows] = op;
    row_arg[nrows] = arg;
    row_dur[nrows] = dur;
    row_reply[nrows] = reply;
    row_en[nrows] = en;
    row_br[nrows] = br;
    row_pair[nrows] = pair;
    row_dir2[nrows] = dir2;
    row_dur2[nrows] = dur2;
    nrows = nrows + 1;
  endtask

  // Strobe high four cycles, low four cycles; starts and ends 2 ns after an edge
  task automatic send_word(input logic [63:0] w, output logic [63:0] reply);
    word_data_received = w;
    word_received = 1'b1;
    repeat (4) @(posedge CLK);
    #1 reply = word_send_data;
    #1 word_received = 1'b0;
    repeat (4) @(posedge CLK);
    #2;
  endtask

  task automatic wait_done(input integer target);
    do begin
      @(posedge CLK);
      #1;
    end while (done_cnt < target);
    #1;
  endtask

  // One move with random rates and zero accel; updates the step and position model
  task automatic send_move(input logic [1:0] mdir, input logic [31:0] dur, input logic chk_pos);
    logic [63:0] reply, prod;
    logic [31:0] rate, n;
    send_word({motion_pkg::COORDINATED_STEP, 54'h0, mdir}, reply);
    check("word_send_data after move header", reply, 64'h0);
    send_word({32'h0, dur}, reply);
    if (chk_pos) check("word_send_data position axis 0", reply,
                       {{32{pos_model[0][31]}}, pos_model[0]});
    for (int a = 0; a < NAX; a++) begin
      rate = $random(seed);
      send_word({32'h0, rate}, reply);
      check("word_send_data after rate", reply, 64'h0);
      send_word(64'h0, reply);
      if (a == NAX - 1) check("word_send_data after last accel", reply, 64'h0);
      else if (chk_pos) check("word_send_data position next axis", reply,
                              {{32{pos_model[a+1][31]}}, pos_model[a+1]});
      prod = {32'h0, rate} * {32'h0, dur};
      n = prod[63:32];  // floor(N*I / 2^32)
      exp_steps[a] = exp_steps[a] + n;
      pos_model[a] = mdir[a] ? pos_model[a] + n : pos_model[a] - n;
    end
  endtask

  task automatic run_moves(input integer r);
    integer base;
    base = done_cnt;
    check("buffer_dtr before move", buffer_dtr, 1'b1);
    send_move(row_arg[r][1:0], row_dur[r], 1'b1);
    if (row_pair[r]) begin
      send_move(row_dir2[r], row_dur2[r], 1'b0);  // First move still running
      check("buffer_dtr after second commit", buffer_dtr, 1'b0);
      wait_done(base + 1);
      check("buffer_dtr after first retire", buffer_dtr, 1'b1);
      wait_done(base + 2);
      check("dir of second move", dir_hist[base + 1], row_dir2[r]);
    end else begin
      wait_done(base + 1);
    end
    check("dir of move", dir_hist[base], row_arg[r][1:0]);
    repeat (20) @(posedge CLK);
    #2;
    check("move_done pulses", done_cnt - base, row_pair[r] ? 2 : 1);
    check("step count axis 0", step_cnt[0], exp_steps[0]);
    check("step count axis 1", step_cnt[1], exp_steps[1]);
  endtask

  task automatic apply_row(input integer r);
    logic [63:0] reply;
    integer err_before;
    err_before = errors;
    case (row_op[r])
      motion_pkg::COORDINATED_STEP: run_moves(r);
      motion_pkg::API_VERSION: begin
        send_word({row_op[r], row_arg[r]}, reply);
        check("word_send_data version", reply, row_reply[r]);
        send_word({motion_pkg::MOTOR_ENABLE, 56'h3}, reply);  // Swallowed
        check("word_send_data after tail word", reply, 64'h0);
      end
      default: begin
        send_word({row_op[r], row_arg[r]}, reply);
        check("word_send_data", reply, row_reply[r]);
      end
    endcase
    check("enable", enable, row_en[r]);
    check("brake", brake, row_br[r]);
    $display("Test %0d: header %h finished with %0d errors", r, row_op[r], errors - err_before);
  endtask

  // Watchdog sized from move lengths and a margin per row
  initial begin
    wait (table_ready);
    repeat (watchdog_cycles) @(posedge CLK);
    $display("Timeout: run did not finish within %0d cycles", watchdog_cycles);
    $display("Checks failed");
    $finish;
  end

  initial begin
    integer div;
    resetn = 1'b1;
    word_received = 1'b0;
    word_data_received = '0;
    for (int a = 0; a < NAX; a++) begin
      exp_steps[a] = 0;
      pos_model[a] = 0;
    end
    add_row(motion_pkg::API_VERSION, 56'h0, 0, {32'h0, `VERSION_DEVEL, `VERSION_MAJOR,
            `VERSION_MINOR, `VERSION_PATCH}, 2'b00, 2'b00, 1'b0, 2'b00, 0);
    add_row(motion_pkg::MOTOR_ENABLE, 56'h3, 0, 64'h0, 2'b11, 2'b00, 1'b0, 2'b00, 0);
    add_row(motion_pkg::MOTOR_BRAKE, 56'h6, 0, 64'h0, 2'b11, 2'b10, 1'b0, 2'b00, 0);
    add_row(8'h55, 56'habcdef, 0, 64'h0, 2'b11, 2'b10, 1'b0, 2'b00, 0);  // Unknown header
    add_row(motion_pkg::CLK_DIVISOR, 56'h6, 0, 64'h0, 2'b11, 2'b10, 1'b0, 2'b00, 0);
    add_row(motion_pkg::COORDINATED_STEP, 56'h1, 40, 64'h0, 2'b11, 2'b10, 1'b0, 2'b00, 0);
    add_row(motion_pkg::COORDINATED_STEP, 56'h2, 30, 64'h0, 2'b11, 2'b10, 1'b0, 2'b00, 0);
    add_row(motion_pkg::COORDINATED_STEP, 56'h3, 40, 64'h0, 2'b11, 2'b10, 1'b1, 2'b00, 20);
    div = `DEFAULT_DIVISOR;
    watchdog_cycles = 100;
    for (i = 0; i < nrows; i++) begin
      if (row_op[i] == motion_pkg::CLK_DIVISOR && row_arg[i][7:0] > div) div = row_arg[i][7:0];
    end
    for (i = 0; i < nrows; i++) begin
      watchdog_cycles = watchdog_cycles + (row_dur[i] + row_dur2[i]) * (div + 1) + 300;
    end
    table_ready = 1'b1;
    repeat (16) @(posedge CLK);
    #2 resetn = 1'b0;
    @(posedge CLK);
    #1;
    check("step", step, '0);
    check("enable", enable, '0);
    check("brake", brake, '0);
    check("move_done", move_done, 1'b0);
    check("buffer_dtr", buffer_dtr, 1'b1);
    check("word_send_data", word_send_data, 64'h0);
    $display("Test reset finished with %0d errors", errors);
    #1;
    for (i = 0; i < nrows; i++) apply_row(i);
    $display("Summary: %0d checks, %0d errors", n_checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
